// ==== common/gamePkg.sv ====
// Shared types and constants; glyph bounds assume a 640x480 visible area and a smaller VGA simply shows no glyph
package gamePkg;

	// --------------------------------------------------
	// Screen states of the menu FSM
	// --------------------------------------------------
	typedef enum logic [3:0] {
		Initial,
		MenuPlay,
		MenuPractice,
		MenuScores,
		MenuQuit,
		PlayInitial,
		PracticeInitial,
		Practice,
		Scores,
		Done
	} gameState;

	// Switch and LED word
	typedef logic [7:0] switchValue;

	// One decimal digit
	typedef logic [3:0] bcdDigit;

	// Colour bits, red in bit 2 and blue in bit 0
	typedef logic [2:0] rgbColour;

	// Number of seven-segment digits on the board
	localparam int digitCount = 4;

	// --------------------------------------------------
	// Seven-segment cathodes, active low
	// --------------------------------------------------
	// Bit order is a b c d e f g Dp, Dp kept dark
	localparam logic [7:0] segmentTable [10] = '{
		8'b0000_0011,
		8'b1001_1111,
		8'b0010_0101,
		8'b0000_1101,
		8'b1001_1001,
		8'b0100_1001,
		8'b0100_0001,
		8'b0001_1111,
		8'b0000_0001,
		8'b0000_1001
	};
	// All segments dark
	localparam logic [7:0] segmentBlank = 8'hFF;

	// --------------------------------------------------
	// Menu glyph geometry, inclusive pixel bounds
	// --------------------------------------------------
	localparam int glyphTop     = 100;
	localparam int glyphBottom  = 280;
	localparam int topBarBottom = 140;
	localparam int topBarLeft   = 240;
	localparam int topBarRight  = 400;
	localparam int barLeft0     = 240;
	localparam int barRight0    = 270;
	localparam int barLeft1     = 305;
	localparam int barRight1    = 335;
	localparam int barLeft2     = 370;
	localparam int barRight2    = 400;

endpackage

// ==== design/buttonConditioner.sv ====
// Button must already be synchronous to sys_clk; debounceCycles of at least 1
`timescale 1ns/100ps

module buttonConditioner #(
	parameter int debounceCycles = 16
) (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	input  logic button,
	output logic press
);

	// Counter wide enough to hold debounceCycles
	localparam int countWidth = $clog2(debounceCycles + 1);
	localparam logic [countWidth-1:0] countLast = countWidth'(debounceCycles - 1);

	logic [countWidth-1:0] stableCount;
	// High while waiting for a press, low while waiting for release
	logic armed;
	// Level the counter is currently looking for
	logic wantedLevel;

	assign wantedLevel = armed ? button : ~button;

	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			stableCount <= '0;
			armed <= 1'b1;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			if (!wantedLevel) begin
				// Bounce or wrong level, start over
				stableCount <= '0;
			end else if (stableCount == countLast) begin
				// Level held long enough, flip phase
				stableCount <= '0;
				armed <= ~armed;
				// Pulse only on the press side, not on release
				press <= armed;
			end else begin
				stableCount <= stableCount + 1'b1;
			end
		end
	end

endmodule

// ==== design/menuController.sv ====
// Presses are single-cycle pulses; if several arrive together quit wins, then select, then right, then left
`timescale 1ns/100ps

module menuController (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	input  logic selectPress,
	input  logic quitPress,
	input  logic leftPress,
	input  logic rightPress,
	output gamePkg::gameState state
);

	gamePkg::gameState nextState;

	// --------------------------------------------------
	// Next-state logic
	// --------------------------------------------------
	always_comb begin
		nextState = state;
		if (quitPress && state != gamePkg::Done) begin
			// Quit backs out to the top of the menu
			nextState = gamePkg::MenuPlay;
		end else begin
			case (state)
				gamePkg::Initial: begin
					if (selectPress) nextState = gamePkg::MenuPlay;
				end
				gamePkg::MenuPlay: begin
					if (selectPress) nextState = gamePkg::PlayInitial;
					else if (rightPress) nextState = gamePkg::MenuPractice;
					else if (leftPress) nextState = gamePkg::MenuQuit;
				end
				gamePkg::MenuPractice: begin
					if (selectPress) nextState = gamePkg::PracticeInitial;
					else if (rightPress) nextState = gamePkg::MenuScores;
					else if (leftPress) nextState = gamePkg::MenuPlay;
				end
				gamePkg::MenuScores: begin
					if (selectPress) nextState = gamePkg::Scores;
					else if (rightPress) nextState = gamePkg::MenuQuit;
					else if (leftPress) nextState = gamePkg::MenuPractice;
				end
				gamePkg::MenuQuit: begin
					if (selectPress) nextState = gamePkg::Done;
					else if (rightPress) nextState = gamePkg::MenuPlay;
					else if (leftPress) nextState = gamePkg::MenuScores;
				end
				// Second select starts the practice readout
				gamePkg::PracticeInitial: begin
					if (selectPress) nextState = gamePkg::Practice;
				end
				// PlayInitial, Practice and Scores only leave on quit
				// Done holds until reset
				default: nextState = state;
			endcase
		end
	end

	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			state <= gamePkg::Initial;
		end else begin
			state <= nextState;
		end
	end

endmodule

// ==== display/readoutFormatter.sv ====
// Switches are sampled without synchronizer; digits show the switch value in Practice and 0 otherwise
`timescale 1ns/100ps

module readoutFormatter (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	input  gamePkg::switchValue switches,
	input  gamePkg::gameState state,
	output gamePkg::switchValue leds,
	output gamePkg::bcdDigit hundreds,
	output gamePkg::bcdDigit tens,
	output gamePkg::bcdDigit ones,
	output logic hundredsShown,
	output logic tensShown
);

	gamePkg::switchValue sampled;
	gamePkg::switchValue shownValue;
	logic [11:0] bcdNext;

	// Shift-and-add-three, three BCD nibbles for an 8-bit value
	function automatic logic [11:0] toBcd(input gamePkg::switchValue value);
		logic [11:0] bcd;
		int i;
		bcd = '0;
		for (i = 7; i >= 0; i--) begin
			if (bcd[3:0] >= 4'd5) bcd[3:0] = bcd[3:0] + 4'd3;
			if (bcd[7:4] >= 4'd5) bcd[7:4] = bcd[7:4] + 4'd3;
			if (bcd[11:8] >= 4'd5) bcd[11:8] = bcd[11:8] + 4'd3;
			bcd = {bcd[10:0], value[i]};
		end
		return bcd;
	endfunction

	// Sample stage, LEDs mirror it directly
	always_ff @(posedge sys_clk) begin
		sampled <= switches;
	end
	assign leds = sampled;

	// Only Practice shows the player's number
	assign shownValue = (state == gamePkg::Practice) ? sampled : '0;
	assign bcdNext = toBcd(shownValue);

	// --------------------------------------------------
	// Registered conversion
	// --------------------------------------------------
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			hundreds <= '0;
			tens <= '0;
			ones <= '0;
			hundredsShown <= 1'b0;
			tensShown <= 1'b0;
		end else begin
			hundreds <= bcdNext[11:8];
			tens <= bcdNext[7:4];
			ones <= bcdNext[3:0];
			// Leading zeros stay dark
			hundredsShown <= (bcdNext[11:8] != 4'd0);
			tensShown <= (bcdNext[11:4] != 8'd0);
		end
	end

endmodule

// ==== display/segmentScanner.sv ====
// Scans An2, An1, An0 only; An3 stays dark; ones digit is always lit; scanCycles of at least 2
`timescale 1ns/100ps

module segmentScanner #(
	parameter int scanCycles = 1024
) (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	input  gamePkg::bcdDigit hundreds,
	input  gamePkg::bcdDigit tens,
	input  gamePkg::bcdDigit ones,
	input  logic hundredsShown,
	input  logic tensShown,
	output logic [gamePkg::digitCount-1:0] anodes,
	output logic [7:0] cathodes
);

	localparam int scanWidth = $clog2(scanCycles);
	localparam logic [scanWidth-1:0] scanLast = scanWidth'(scanCycles - 1);

	logic [scanWidth-1:0] scanCount;
	// 0 selects hundreds, 1 tens, 2 ones
	logic [1:0] digitIndex;
	gamePkg::bcdDigit digitNow;
	logic shownNow;
	logic [gamePkg::digitCount-1:0] anodeNow;

	// Dwell counter and digit step
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			scanCount <= '0;
			digitIndex <= 2'd0;
		end else if (scanCount == scanLast) begin
			scanCount <= '0;
			digitIndex <= (digitIndex == 2'd2) ? 2'd0 : digitIndex + 2'd1;
		end else begin
			scanCount <= scanCount + 1'b1;
		end
	end

	// Digit mux and anode pattern
	always_comb begin
		case (digitIndex)
			2'd0: begin
				digitNow = hundreds;
				shownNow = hundredsShown;
				anodeNow = 4'b1011;
			end
			2'd1: begin
				digitNow = tens;
				shownNow = tensShown;
				anodeNow = 4'b1101;
			end
			default: begin
				digitNow = ones;
				shownNow = 1'b1;
				anodeNow = 4'b1110;
			end
		endcase
	end

	// Anode and cathode register together so no ghosting between digits
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			anodes <= '1;
			cathodes <= gamePkg::segmentBlank;
		end else begin
			anodes <= anodeNow;
			if (!shownNow || digitNow > 4'd9) cathodes <= gamePkg::segmentBlank;
			else cathodes <= gamePkg::segmentTable[digitNow];
		end
	end

endmodule

// ==== vga/syncGenerator.sv ====
// Total line and frame lengths must fit in 10-bit counters; syncs are active low
`timescale 1ns/100ps

module syncGenerator #(
	parameter int pixelDivide = 4,
	parameter int hVisible    = 640,
	parameter int hFront      = 16,
	parameter int hSyncWidth  = 96,
	parameter int hBack       = 48,
	parameter int vVisible    = 480,
	parameter int vFront      = 10,
	parameter int vSyncWidth  = 2,
	parameter int vBack       = 33
) (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	output logic pixelTick,
	output logic inDisplayArea,
	output logic hSync,
	output logic vSync,
	output logic [9:0] pixelX,
	output logic [9:0] pixelY
);

	localparam int hTotal = hVisible + hFront + hSyncWidth + hBack;
	localparam int vTotal = vVisible + vFront + vSyncWidth + vBack;
	localparam int divWidth = $clog2(pixelDivide + 1);

	logic [divWidth-1:0] divCount;
	logic lineEnd;

	// --------------------------------------------------
	// Pixel tick enable
	// --------------------------------------------------
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) divCount <= '0;
		else if (pixelTick) divCount <= '0;
		else divCount <= divCount + 1'b1;
	end
	assign pixelTick = (divCount == divWidth'(pixelDivide - 1));

	// Horizontal then vertical position
	assign lineEnd = (pixelX == 10'(hTotal - 1));
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			pixelX <= '0;
			pixelY <= '0;
		end else if (pixelTick) begin
			pixelX <= lineEnd ? 10'd0 : pixelX + 10'd1;
			if (lineEnd) pixelY <= (pixelY == 10'(vTotal - 1)) ? 10'd0 : pixelY + 10'd1;
		end
	end

	assign inDisplayArea = (pixelX < 10'(hVisible)) && (pixelY < 10'(vVisible));

	// Syncs registered on the tick, same timing as the renderer colour
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) begin
			hSync <= 1'b1;
			vSync <= 1'b1;
		end else if (pixelTick) begin
			hSync <= ~((pixelX >= 10'(hVisible + hFront)) &&
				(pixelX < 10'(hVisible + hFront + hSyncWidth)));
			vSync <= ~((pixelY >= 10'(vVisible + vFront)) &&
				(pixelY < 10'(vVisible + vFront + vSyncWidth)));
		end
	end

endmodule

// ==== vga/menuRenderer.sv ====
// Colour updates on pixelTick only; glyph bounds come from the shared 640x480 geometry
`timescale 1ns/100ps

module menuRenderer (
	input  logic sys_clk,
	input  logic Reset_Pulse,
	input  gamePkg::gameState state,
	input  logic pixelTick,
	input  logic [9:0] pixelX,
	input  logic [9:0] pixelY,
	input  logic inDisplayArea,
	output gamePkg::rgbColour colour
);

	logic inRows;
	logic inTopBar;
	logic inBars;
	logic glyph;
	gamePkg::rgbColour stateColour;

	// --------------------------------------------------
	// Menu glyph, three columns under a top bar
	// --------------------------------------------------
	assign inRows = (pixelY >= 10'(gamePkg::glyphTop)) && (pixelY <= 10'(gamePkg::glyphBottom));
	assign inTopBar = (pixelY >= 10'(gamePkg::glyphTop)) &&
		(pixelY <= 10'(gamePkg::topBarBottom)) &&
		(pixelX >= 10'(gamePkg::topBarLeft)) && (pixelX <= 10'(gamePkg::topBarRight));
	assign inBars = inRows && (
		((pixelX >= 10'(gamePkg::barLeft0)) && (pixelX <= 10'(gamePkg::barRight0))) ||
		((pixelX >= 10'(gamePkg::barLeft1)) && (pixelX <= 10'(gamePkg::barRight1))) ||
		((pixelX >= 10'(gamePkg::barLeft2)) && (pixelX <= 10'(gamePkg::barRight2))));
	assign glyph = inTopBar || inBars;

	// Colour per screen, bits are red green blue
	always_comb begin
		case (state)
			gamePkg::Initial:         stateColour = 3'b111;
			gamePkg::MenuPlay:        stateColour = {3{glyph}};
			gamePkg::MenuPractice:    stateColour = {glyph, 1'b1, glyph};
			gamePkg::MenuScores:      stateColour = {1'b1, glyph, 1'b1};
			gamePkg::MenuQuit:        stateColour = {1'b1, glyph, glyph};
			gamePkg::PlayInitial:     stateColour = 3'b001;
			gamePkg::PracticeInitial: stateColour = 3'b010;
			gamePkg::Scores:          stateColour = 3'b101;
			// Practice and Done stay dark
			default:                  stateColour = 3'b000;
		endcase
	end

	// Blank outside the visible area
	always_ff @(posedge sys_clk or posedge Reset_Pulse) begin
		if (Reset_Pulse) colour <= '0;
		else if (pixelTick) colour <= stateColour & {3{inDisplayArea}};
	end

endmodule

// ==== design/gameTop.sv ====
// BtnU is the raw asynchronous reset; defaults assume a 100 MHz sys_clk and a 640x480 monitor
`timescale 1ns/100ps

module gameTop #(
	parameter int debounceCycles = 500000,
	parameter int scanCycles     = 262144,
	parameter int pixelDivide    = 4,
	parameter int hVisible       = 640,
	parameter int hFront         = 16,
	parameter int hSyncWidth     = 96,
	parameter int hBack          = 48,
	parameter int vVisible       = 480,
	parameter int vFront         = 10,
	parameter int vSyncWidth     = 2,
	parameter int vBack          = 33
) (
	input  logic sys_clk,
	input  logic BtnU,
	input  logic BtnL,
	input  logic BtnR,
	input  logic BtnC,
	input  logic BtnD,
	input  gamePkg::switchValue Sw,
	output gamePkg::switchValue Ld,
	output logic [gamePkg::digitCount-1:0] An,
	output logic Ca,
	output logic Cb,
	output logic Cc,
	output logic Cd,
	output logic Ce,
	output logic Cf,
	output logic Cg,
	output logic Dp,
	output logic Hsync,
	output logic Vsync,
	output logic vgaRed,
	output logic vgaGreen,
	output logic vgaBlue,
	output gamePkg::gameState state
);

	logic Reset_Pulse;
	logic selectPress;
	logic quitPress;
	logic leftPress;
	logic rightPress;
	gamePkg::bcdDigit hundreds;
	gamePkg::bcdDigit tens;
	gamePkg::bcdDigit ones;
	logic hundredsShown;
	logic tensShown;
	logic [7:0] cathodes;
	logic pixelTick;
	logic inDisplayArea;
	logic [9:0] pixelX;
	logic [9:0] pixelY;
	gamePkg::rgbColour colour;

	// Up button doubles as reset
	assign Reset_Pulse = BtnU;

	// --------------------------------------------------
	// Buttons, centre selects and down quits
	// --------------------------------------------------
	buttonConditioner #(.debounceCycles(debounceCycles)) u_selectButton (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse), .button(BtnC), .press(selectPress));
	buttonConditioner #(.debounceCycles(debounceCycles)) u_quitButton (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse), .button(BtnD), .press(quitPress));
	buttonConditioner #(.debounceCycles(debounceCycles)) u_leftButton (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse), .button(BtnL), .press(leftPress));
	buttonConditioner #(.debounceCycles(debounceCycles)) u_rightButton (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse), .button(BtnR), .press(rightPress));

	menuController u_menuController (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse),
		.selectPress(selectPress), .quitPress(quitPress),
		.leftPress(leftPress), .rightPress(rightPress),
		.state(state));

	// --------------------------------------------------
	// LEDs and seven-segment readout
	// --------------------------------------------------
	readoutFormatter u_readoutFormatter (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse),
		.switches(Sw), .state(state), .leds(Ld),
		.hundreds(hundreds), .tens(tens), .ones(ones),
		.hundredsShown(hundredsShown), .tensShown(tensShown));

	segmentScanner #(.scanCycles(scanCycles)) u_segmentScanner (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse),
		.hundreds(hundreds), .tens(tens), .ones(ones),
		.hundredsShown(hundredsShown), .tensShown(tensShown),
		.anodes(An), .cathodes(cathodes));
	assign {Ca, Cb, Cc, Cd, Ce, Cf, Cg, Dp} = cathodes;

	// --------------------------------------------------
	// VGA
	// --------------------------------------------------
	syncGenerator #(
		.pixelDivide(pixelDivide),
		.hVisible(hVisible), .hFront(hFront), .hSyncWidth(hSyncWidth), .hBack(hBack),
		.vVisible(vVisible), .vFront(vFront), .vSyncWidth(vSyncWidth), .vBack(vBack)
	) u_syncGenerator (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse),
		.pixelTick(pixelTick), .inDisplayArea(inDisplayArea),
		.hSync(Hsync), .vSync(Vsync), .pixelX(pixelX), .pixelY(pixelY));

	menuRenderer u_menuRenderer (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse), .state(state),
		.pixelTick(pixelTick), .pixelX(pixelX), .pixelY(pixelY),
		.inDisplayArea(inDisplayArea), .colour(colour));
	assign {vgaRed, vgaGreen, vgaBlue} = colour;

endmodule

// ==== dv/tbClockGen.sv ====
// Free-running clock from time zero; reset is high at start and drops after resetCycles rising edges
`timescale 1ns/100ps

module tbClockGen #(
	parameter int halfPeriod  = 2,
	parameter int resetCycles = 10
) (
	output logic sys_clk,
	output logic Reset_Pulse
);

	// 4 ns period with the default half period
	initial begin
		sys_clk = 1'b0;
		forever #(halfPeriod) sys_clk = ~sys_clk;
	end

	// Reset released on a rising edge
	initial begin
		Reset_Pulse = 1'b1;
		repeat (resetCycles) @(posedge sys_clk);
		Reset_Pulse <= 1'b0;
	end

endmodule

// ==== dv/gameTopTb.sv ====
// Small debounce, scan and VGA sizes; the 40x20 test screen lies above the menu glyph rows
`timescale 1ns/100ps

module gameTopTb;

	// --------------------------------------------------
	// DUT sizes and run length
	// --------------------------------------------------
	localparam int debounceCycles = 3;
	localparam int scanCycles     = 8;
	localparam int pixelDivide    = 2;
	localparam int hVisible       = 40;
	localparam int hFront         = 4;
	localparam int hSyncWidth     = 6;
	localparam int hBack          = 4;
	localparam int vVisible       = 20;
	localparam int vFront         = 2;
	localparam int vSyncWidth     = 2;
	localparam int vBack          = 2;
	localparam int resetCycles    = 10;
	localparam int tableRows      = 42;
	localparam int holdCycles     = debounceCycles + 2;
	localparam int hTotal         = hVisible + hFront + hSyncWidth + hBack;
	localparam int vTotal         = vVisible + vFront + vSyncWidth + vBack;
	localparam int frameCycles    = hTotal * vTotal * pixelDivide;
	// Switch settle, push, digit scan and one frame per row
	localparam int rowCycles      = 4 + 2 * holdCycles + 4 * scanCycles + frameCycles;
	localparam int timeoutLimit   = 2 * (resetCycles + tableRows * rowCycles);

	// Button codes in the table
	localparam logic [2:0] btnNone   = 3'd0;
	localparam logic [2:0] btnSelect = 3'd1;
	localparam logic [2:0] btnQuit   = 3'd2;
	localparam logic [2:0] btnLeft   = 3'd3;
	localparam logic [2:0] btnRight  = 3'd4;

	// Table row with button, random switch flag, switch word and expected screen
	typedef struct packed {
		logic [2:0] button;
		logic randomSw;
		logic [7:0] sw;
		gamePkg::gameState expected;
	} stimRow;

	logic sys_clk;
	logic Reset_Pulse;
	logic BtnL;
	logic BtnR;
	logic BtnC;
	logic BtnD;
	gamePkg::switchValue Sw;
	gamePkg::switchValue Ld;
	logic [gamePkg::digitCount-1:0] An;
	logic Ca;
	logic Cb;
	logic Cc;
	logic Cd;
	logic Ce;
	logic Cf;
	logic Cg;
	logic Dp;
	logic Hsync;
	logic Vsync;
	logic vgaRed;
	logic vgaGreen;
	logic vgaBlue;
	gamePkg::gameState state;

	stimRow rowTable [tableRows];
	int rowCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int hLowCount = 0;
	int vLowCount = 0;
	int hPulses = 0;
	int vPulses = 0;
	integer seed = 32'hcef9_bb8c;

	tbClockGen #(.halfPeriod(2), .resetCycles(resetCycles)) u_clockGen (
		.sys_clk(sys_clk), .Reset_Pulse(Reset_Pulse));

	gameTop #(
		.debounceCycles(debounceCycles), .scanCycles(scanCycles), .pixelDivide(pixelDivide),
		.hVisible(hVisible), .hFront(hFront), .hSyncWidth(hSyncWidth), .hBack(hBack),
		.vVisible(vVisible), .vFront(vFront), .vSyncWidth(vSyncWidth), .vBack(vBack)
	) u_gameTop (
		.sys_clk(sys_clk), .BtnU(Reset_Pulse), .BtnL(BtnL), .BtnR(BtnR), .BtnC(BtnC),
		.BtnD(BtnD), .Sw(Sw), .Ld(Ld), .An(An), .Ca(Ca), .Cb(Cb), .Cc(Cc), .Cd(Cd),
		.Ce(Ce), .Cf(Cf), .Cg(Cg), .Dp(Dp), .Hsync(Hsync), .Vsync(Vsync),
		.vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue), .state(state));

	// --------------------------------------------------
	// Checking helpers
	// --------------------------------------------------
	task automatic compareValue(input int actual, input int expected, input string what);
		checkCount++;
		assert (actual == expected) else begin
			errorCount++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic confirm(input logic condition, input string message);
		checkCount++;
		assert (condition) else begin
			errorCount++;
			$display("Error at %0t: %s", $time, message);
		end
	endtask

	// Cathode byte for one digit or blank for a leading zero
	function automatic logic [7:0] digitPattern(input int digit, input logic shown);
		return shown ? gamePkg::segmentTable[digit] : gamePkg::segmentBlank;
	endfunction

	// Background colour per screen in red green blue order
	// Glyph rows start far below the test screen so menus show background only
	function automatic gamePkg::rgbColour solidColour(input gamePkg::gameState s);
		case (s)
			gamePkg::Initial:         return 3'b111;
			gamePkg::MenuPractice:    return 3'b010;
			gamePkg::MenuScores:      return 3'b101;
			gamePkg::MenuQuit:        return 3'b100;
			gamePkg::PlayInitial:     return 3'b001;
			gamePkg::PracticeInitial: return 3'b010;
			gamePkg::Scores:          return 3'b101;
			default:                  return 3'b000;
		endcase
	endfunction

	task automatic addRow(input logic [2:0] button, input logic randomSw, input logic [7:0] sw,
			input gamePkg::gameState expected);
		rowTable[rowCount] = '{button, randomSw, sw, expected};
		rowCount++;
	endtask

	// Every menu move, both wraps, quit returns and Done holding
	task automatic buildTable();
		addRow(btnNone,   1'b0, 8'h00, gamePkg::Initial);
		addRow(btnLeft,   1'b0, 8'h3C, gamePkg::Initial);
		addRow(btnSelect, 1'b0, 8'hA5, gamePkg::MenuPlay);
		addRow(btnRight,  1'b0, 8'h01, gamePkg::MenuPractice);
		addRow(btnRight,  1'b0, 8'h02, gamePkg::MenuScores);
		addRow(btnRight,  1'b0, 8'h04, gamePkg::MenuQuit);
		addRow(btnRight,  1'b0, 8'h08, gamePkg::MenuPlay);
		addRow(btnLeft,   1'b0, 8'h10, gamePkg::MenuQuit);
		addRow(btnLeft,   1'b0, 8'h20, gamePkg::MenuScores);
		addRow(btnLeft,   1'b0, 8'h40, gamePkg::MenuPractice);
		addRow(btnLeft,   1'b0, 8'h80, gamePkg::MenuPlay);
		addRow(btnSelect, 1'b0, 8'hFF, gamePkg::PlayInitial);
		addRow(btnRight,  1'b0, 8'h5A, gamePkg::PlayInitial);
		addRow(btnQuit,   1'b0, 8'h00, gamePkg::MenuPlay);
		addRow(btnRight,  1'b0, 8'h00, gamePkg::MenuPractice);
		addRow(btnSelect, 1'b0, 8'h11, gamePkg::PracticeInitial);
		addRow(btnQuit,   1'b0, 8'h22, gamePkg::MenuPlay);
		addRow(btnRight,  1'b0, 8'h33, gamePkg::MenuPractice);
		addRow(btnSelect, 1'b0, 8'h44, gamePkg::PracticeInitial);
		// Practice readout, blanking and inner zeros
		addRow(btnSelect, 1'b0, 8'd0,   gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd7,   gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd45,  gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd100, gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd255, gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd10,  gamePkg::Practice);
		addRow(btnNone,   1'b0, 8'd109, gamePkg::Practice);
		addRow(btnNone,   1'b1, 8'd0,   gamePkg::Practice);
		addRow(btnNone,   1'b1, 8'd0,   gamePkg::Practice);
		addRow(btnNone,   1'b1, 8'd0,   gamePkg::Practice);
		addRow(btnLeft,   1'b1, 8'd0,   gamePkg::Practice);
		addRow(btnQuit,   1'b0, 8'h99, gamePkg::MenuPlay);
		addRow(btnRight,  1'b0, 8'h77, gamePkg::MenuPractice);
		addRow(btnRight,  1'b0, 8'h66, gamePkg::MenuScores);
		addRow(btnSelect, 1'b0, 8'h55, gamePkg::Scores);
		addRow(btnSelect, 1'b0, 8'hC3, gamePkg::Scores);
		addRow(btnQuit,   1'b0, 8'h0F, gamePkg::MenuPlay);
		addRow(btnLeft,   1'b0, 8'hF0, gamePkg::MenuQuit);
		addRow(btnSelect, 1'b0, 8'h81, gamePkg::Done);
		// Done ignores every button
		addRow(btnQuit,   1'b0, 8'h42, gamePkg::Done);
		addRow(btnSelect, 1'b0, 8'h24, gamePkg::Done);
		addRow(btnRight,  1'b0, 8'h18, gamePkg::Done);
		addRow(btnLeft,   1'b0, 8'hE7, gamePkg::Done);
	endtask

	// --------------------------------------------------
	// Stimulus tasks
	// --------------------------------------------------
	// Button high then low for long enough to pass the debouncer
	task automatic pushButton(input logic [2:0] which);
		logic level;
		int i;
		for (i = 0; i < 2 * holdCycles; i++) begin
			@(posedge sys_clk);
			level = (i < holdCycles);
			case (which)
				btnSelect: BtnC <= level;
				btnQuit:   BtnD <= level;
				btnLeft:   BtnL <= level;
				btnRight:  BtnR <= level;
				default:   ;
			endcase
		end
		@(posedge sys_clk);
	endtask

	// Cathodes checked against the lit anode over a few scan rounds
	task automatic scanDigits(input int value);
		int hundredsDigit;
		int tensDigit;
		int onesDigit;
		logic [2:0] seen;
		logic [7:0] cath;
		int i;
		hundredsDigit = value / 100;
		tensDigit = (value / 10) % 10;
		onesDigit = value % 10;
		seen = '0;
		for (i = 0; i < 4 * scanCycles; i++) begin
			@(negedge sys_clk);
			cath = {Ca, Cb, Cc, Cd, Ce, Cf, Cg, Dp};
			confirm(An[3], "An3 was driven low");
			case (An)
				4'b1011: begin
					seen[2] = 1'b1;
					compareValue(cath, digitPattern(hundredsDigit, hundredsDigit != 0),
						"hundreds cathodes");
				end
				4'b1101: begin
					seen[1] = 1'b1;
					compareValue(cath, digitPattern(tensDigit,
						hundredsDigit != 0 || tensDigit != 0), "tens cathodes");
				end
				4'b1110: begin
					seen[0] = 1'b1;
					compareValue(cath, digitPattern(onesDigit, 1'b1), "ones cathodes");
				end
				default: confirm(1'b0, "no single digit anode was low");
			endcase
		end
		confirm(seen == 3'b111, "a digit anode never went low during the scan");
	endtask

	// Lit pixels of one full frame carry the screen colour over the whole visible area
	task automatic watchFrame(input gamePkg::rgbColour expected);
		gamePkg::rgbColour seenColour;
		int lit;
		int i;
		lit = 0;
		for (i = 0; i < frameCycles; i++) begin
			@(negedge sys_clk);
			seenColour = {vgaRed, vgaGreen, vgaBlue};
			if (seenColour != 3'b000) begin
				lit++;
				compareValue(seenColour, expected, "VGA colour");
			end
		end
		compareValue(lit, (expected != 3'b000) ? hVisible * vVisible * pixelDivide : 0,
			"lit cycles in a frame");
	endtask

	// --------------------------------------------------
	// Sync widths and blanking checked all through the run
	// --------------------------------------------------
	always @(negedge sys_clk) begin
		if (Reset_Pulse) begin
			hLowCount = 0;
			vLowCount = 0;
		end else begin
			if (!Hsync) begin
				hLowCount++;
			end else if (hLowCount != 0) begin
				compareValue(hLowCount, hSyncWidth * pixelDivide, "Hsync low cycles");
				hPulses++;
				hLowCount = 0;
			end
			if (!Vsync) begin
				vLowCount++;
			end else if (vLowCount != 0) begin
				// Whole lines of hTotal pixels
				compareValue(vLowCount, vSyncWidth * hTotal * pixelDivide, "Vsync low cycles");
				vPulses++;
				vLowCount = 0;
			end
			if (!Hsync || !Vsync) compareValue({vgaRed, vgaGreen, vgaBlue}, 0, "colour in sync");
		end
	end

	// Run length guard
	always @(posedge sys_clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			errorCount++;
			$display("Error at %0t: run did not finish within %0d cycles", $time, timeoutLimit);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		stimRow row;
		gamePkg::switchValue swNow;
		int r;
		BtnL = 1'b0;
		BtnR = 1'b0;
		BtnC = 1'b0;
		BtnD = 1'b0;
		Sw = '0;
		buildTable();
		confirm(rowCount == tableRows, "stimulus table length is wrong");

		// Outputs while reset is held
		@(posedge sys_clk);
		@(negedge sys_clk);
		compareValue(state, gamePkg::Initial, "state in reset");
		compareValue(An, 4'hF, "anodes in reset");
		compareValue(Hsync, 1, "Hsync in reset");
		compareValue(Vsync, 1, "Vsync in reset");
		compareValue({vgaRed, vgaGreen, vgaBlue}, 0, "colour in reset");
		wait (Reset_Pulse == 1'b0);

		for (r = 0; r < tableRows; r++) begin
			row = rowTable[r];
			if (row.randomSw) swNow = 8'($random(seed));
			else swNow = row.sw;
			@(posedge sys_clk);
			Sw <= swNow;
			// LEDs follow two cycles later
			repeat (2) @(posedge sys_clk);
			@(negedge sys_clk);
			compareValue(Ld, swNow, "Ld");
			pushButton(row.button);
			@(negedge sys_clk);
			compareValue(state, row.expected, "state");
			// Readout shows the switches only in Practice
			scanDigits((row.expected == gamePkg::Practice) ? int'(swNow) : 0);
			watchFrame(solidColour(row.expected));
		end

		confirm(hPulses > 0, "no Hsync pulse was seen");
		confirm(vPulses > 0, "no Vsync pulse was seen");
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
common/gamePkg.sv
design/buttonConditioner.sv
design/menuController.sv
display/readoutFormatter.sv
display/segmentScanner.sv
vga/syncGenerator.sv
vga/menuRenderer.sv
design/gameTop.sv
dv/tbClockGen.sv
dv/gameTopTb.sv

// ==== Makefile ====
TOP := gameTopTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
